// File: bench/hybche_tb.sv
// Memory answers in 1 to 3 cycles; expected hit or miss comes from memory traffic only
`include "hybche_consts.svh"

module hybche_tb
  import hybche_addr_pkg::*, hybche_ctrl_pkg::*;
();

  localparam logic [1:0] PRIV_U  = 2'd0;
  localparam logic [1:0] PRIV_M  = 2'd3;
  localparam int         TIMEOUT = 100;

  logic                      clk_i;
  logic                      rst_ni;
  logic                      core_req_valid_i;
  core_req_t                 core_req_i;
  logic                      busy_o;
  logic                      core_rvalid_o;
  logic [`HYBCHE_WORD_W-1:0] core_rdata_o;
  logic                      mem_req_o;
  mem_cmd_t                  mem_cmd_o;
  logic                      mem_ack_i;
  logic [`HYBCHE_WORD_W-1:0] mem_rdata_i;
  logic                      cfg_we_i;
  cache_cfg_t                cfg_i;
  logic [1:0]                priv_lvl_i;
  logic                      flush_i;
  logic                      flush_ack_o;

  // Reference contents of main memory by word address
  logic [`HYBCHE_WORD_W-1:0] ref_mem [0:(1 << `HYBCHE_ADDR_W)-1];
  mem_cmd_t                  mem_log [$];
  logic [31:0]               lcg_state = 32'd41;
  int                        wait_cnt  = -1;
  int                        word_errs = 0;
  int                        bit_errs  = 0;
  int                        cmd_errs  = 0;
  int                        other_errs = 0;

  hybche_top DUT (.*);

  always #10 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic [15:0] make_addr(input logic [11:0] tag, input logic [1:0] idx,
                                            input logic [1:0] off);
    return {tag, idx, off};
  endfunction

  ////////////////////////////////////////////////////////////
  // Memory model
  ////////////////////////////////////////////////////////////

  // Acknowledge after a random wait and log every command
  always @(negedge clk_i) begin
    mem_ack_i = 1'b0;
    if (rst_ni && mem_req_o) begin
      if (wait_cnt < 0) begin
        wait_cnt = int'((lcg_next() >> 16) % 3);
      end
      if (wait_cnt == 0) begin
        mem_log.push_back(mem_cmd_o);
        if (!mem_cmd_o.we) begin
          mem_rdata_i = ref_mem[mem_cmd_o.addr];
        end
        mem_ack_i = 1'b1;
        wait_cnt  = -1;
      end else begin
        wait_cnt--;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////

  task automatic word_matches(input string name, input logic [`HYBCHE_WORD_W-1:0] got,
                              input logic [`HYBCHE_WORD_W-1:0] exp);
    if (got !== exp) begin
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
      word_errs++;
    end
  endtask

  task automatic bit_matches(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
      bit_errs++;
    end
  endtask

  // Write data only carries meaning on a memory write
  task automatic cmd_matches(input string name, input mem_cmd_t got, input mem_cmd_t exp);
    if ((got.we !== exp.we) || (got.addr !== exp.addr) ||
        (exp.we && (got.wdata !== exp.wdata))) begin
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
      cmd_errs++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Bus drivers
  ////////////////////////////////////////////////////////////

  task automatic wait_idle();
    int cnt;
    cnt = 0;
    while (busy_o && cnt < TIMEOUT) begin
      @(negedge clk_i);
      cnt++;
    end
    if (busy_o) begin
      $display("Timeout at %0t: busy_o never fell", $time);
      other_errs++;
    end
  endtask

  // Hit is judged by memory traffic during the read
  task automatic read_access(input logic [15:0] addr, input logic exp_hit);
    int        n0;
    int        cnt;
    logic      got_hit;
    mem_cmd_t  exp_cmd;
    core_req_t req;
    wait_idle();
    n0        = mem_log.size();
    req.we    = 1'b0;
    req.addr  = addr;
    req.wdata = '0;
    core_req_i       = req;
    core_req_valid_i = 1'b1;
    @(negedge clk_i);
    core_req_valid_i = 1'b0;
    bit_matches("busy_o", busy_o, !exp_hit);
    // A hit answers in the very next cycle
    if (exp_hit) begin
      bit_matches("core_rvalid_o", core_rvalid_o, 1'b1);
    end
    cnt = 0;
    while (!core_rvalid_o && cnt < TIMEOUT) begin
      @(negedge clk_i);
      cnt++;
    end
    if (!core_rvalid_o) begin
      $display("Timeout at %0t: no read response for address %h", $time, addr);
      other_errs++;
    end else begin
      got_hit = (mem_log.size() == n0);
      bit_matches("hit", got_hit, exp_hit);
      bit_matches("busy_o", busy_o, 1'b0);
      word_matches("core_rdata_o", core_rdata_o, ref_mem[addr]);
      if (!got_hit && (mem_log.size() - n0 != 4)) begin
        $display("Refill of address %h gave %0d memory commands instead of 4",
                 addr, mem_log.size() - n0);
        other_errs++;
      end else if (!got_hit) begin
        for (int b = 0; b < 4; b++) begin
          exp_cmd.we    = 1'b0;
          exp_cmd.addr  = {addr[15:2], 2'(b)};
          exp_cmd.wdata = '0;
          cmd_matches("mem_cmd_o", mem_log[n0 + b], exp_cmd);
        end
      end
    end
  endtask

  // Exactly one memory write per core write
  task automatic write_access(input logic [15:0] addr, input logic [31:0] data);
    int        n0;
    mem_cmd_t  exp_cmd;
    core_req_t req;
    wait_idle();
    n0        = mem_log.size();
    req.we    = 1'b1;
    req.addr  = addr;
    req.wdata = data;
    core_req_i       = req;
    core_req_valid_i = 1'b1;
    @(negedge clk_i);
    core_req_valid_i = 1'b0;
    bit_matches("busy_o", busy_o, 1'b1);
    wait_idle();
    if (mem_log.size() - n0 != 1) begin
      $display("Write to %h gave %0d memory commands instead of 1", addr, mem_log.size() - n0);
      other_errs++;
    end else begin
      exp_cmd.we    = 1'b1;
      exp_cmd.addr  = addr;
      exp_cmd.wdata = data;
      cmd_matches("mem_cmd_o", mem_log[n0], exp_cmd);
    end
    ref_mem[addr] = data;
  endtask

  task automatic apply_cfg(input force_mode_e fm, input repl_policy_e rp);
    cfg_i    = '{force_mode: fm, repl_policy: rp};
    cfg_we_i = 1'b1;
    @(negedge clk_i);
    cfg_we_i = 1'b0;
  endtask

  task automatic set_priv(input logic [1:0] priv);
    priv_lvl_i = priv;
    @(negedge clk_i);
  endtask

  // Acknowledge must be a single pulse one cycle after the request
  task automatic flush_pulse();
    wait_idle();
    bit_matches("flush_ack_o", flush_ack_o, 1'b0);
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    bit_matches("flush_ack_o", flush_ack_o, 1'b1);
    @(negedge clk_i);
    bit_matches("flush_ack_o", flush_ack_o, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic miss_then_hit();
    set_priv(PRIV_U);
    read_access(make_addr(12'h0a1, 2'd1, 2'd1), 1'b0);
    read_access(make_addr(12'h0a1, 2'd1, 2'd2), 1'b1);
  endtask

  // Cached word takes the new data and an uncached word allocates no line
  task automatic write_through();
    logic [15:0] a;
    logic [31:0] d;
    a = make_addr(12'h0a1, 2'd1, 2'd3);
    d = lcg_next();
    write_access(a, d);
    read_access(a, 1'b1);
    a = make_addr(12'h3c5, 2'd0, 2'd2);
    d = lcg_next();
    write_access(a, d);
    read_access(a, 1'b0);
  endtask

  // Five lines of one set and then the first one again
  task automatic conflict_run(input logic [1:0] priv, input logic last_hit);
    set_priv(priv);
    flush_pulse();
    for (int i = 0; i < 5; i++) begin
      read_access(make_addr(12'h100 + 12'(i), 2'd2, 2'd0), 1'b0);
    end
    read_access(make_addr(12'h100, 2'd2, 2'd1), last_hit);
  endtask

  task automatic assoc_conflict();
    conflict_run(PRIV_U, 1'b0);
    conflict_run(PRIV_M, 1'b1);
  endtask

  task automatic mode_policy();
    logic [15:0] a;
    a = make_addr(12'h2f0, 2'd3, 2'd1);
    set_priv(PRIV_U);
    apply_cfg(FORCE_DYNAMIC, REPL_RETAIN);
    flush_pulse();
    read_access(a, 1'b0);
    // Retained across both switches
    set_priv(PRIV_M);
    read_access(a, 1'b1);
    set_priv(PRIV_U);
    read_access(a, 1'b1);
    apply_cfg(FORCE_DYNAMIC, REPL_FLUSH);
    set_priv(PRIV_M);
    read_access(a, 1'b0);
    apply_cfg(FORCE_DYNAMIC, REPL_RETAIN);
  endtask

  task automatic forced_mode_flush();
    apply_cfg(FORCE_SET_ASSOC, REPL_RETAIN);
    conflict_run(PRIV_M, 1'b0);
    flush_pulse();
    for (int i = 0; i < 5; i++) begin
      read_access(make_addr(12'h100 + 12'(i), 2'd2, 2'd3), 1'b0);
    end
    apply_cfg(FORCE_DYNAMIC, REPL_RETAIN);
  endtask

  initial begin
    clk_i            = 1'b0;
    rst_ni           = 1'b0;
    core_req_valid_i = 1'b0;
    core_req_i       = '0;
    mem_ack_i        = 1'b0;
    mem_rdata_i      = '0;
    cfg_we_i         = 1'b0;
    cfg_i            = '{force_mode: FORCE_DYNAMIC, repl_policy: REPL_RETAIN};
    priv_lvl_i       = PRIV_U;
    flush_i          = 1'b0;
    for (int a = 0; a < (1 << `HYBCHE_ADDR_W); a++) begin
      ref_mem[16'(a)] = lcg_next();
    end
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    // Quiet outputs after reset
    bit_matches("mem_req_o", mem_req_o, 1'b0);
    bit_matches("busy_o", busy_o, 1'b0);
    bit_matches("core_rvalid_o", core_rvalid_o, 1'b0);
    bit_matches("flush_ack_o", flush_ack_o, 1'b0);
    miss_then_hit();
    write_through();
    assoc_conflict();
    mode_policy();
    forced_mode_flush();
    $display("Errors: word %0d, bit %0d, command %0d, other %0d",
             word_errs, bit_errs, cmd_errs, other_errs);
    if (word_errs + bit_errs + cmd_errs + other_errs == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: design/hybche_addr_pkg.sv
// Address views assume word addressing; tag and line widths follow the geometry macros
`include "hybche_consts.svh"

package hybche_addr_pkg;

  // Set-associative view of a word address
  typedef struct packed {
    logic [`HYBCHE_ADDR_W-`HYBCHE_IDX_W-`HYBCHE_OFF_W-1:0] tag;
    logic [`HYBCHE_IDX_W-1:0]                             index;
    logic [`HYBCHE_OFF_W-1:0]                             offset;
  } sa_addr_t;

  // Fully-associative view, whole line address acts as tag
  typedef struct packed {
    logic [`HYBCHE_ADDR_W-`HYBCHE_OFF_W-1:0] line_addr;
    logic [`HYBCHE_OFF_W-1:0]               offset;
  } fa_addr_t;

  // Same 16 bits, decoded per placement mode
  typedef union packed {
    sa_addr_t sa;
    fa_addr_t fa;
  } cache_addr_u;

  // Full line address, stored as tag in every slot
  typedef logic [`HYBCHE_ADDR_W-`HYBCHE_OFF_W-1:0] line_addr_t;

  // Line slot number
  typedef logic [`HYBCHE_LINE_ID_W-1:0] line_id_t;

  // One line of data words
  typedef logic [(1 << `HYBCHE_OFF_W)-1:0][`HYBCHE_WORD_W-1:0] line_data_t;

endpackage

// File: design/hybche_consts.svh
// Cache geometry in word addresses; LINES must equal WAYS << IDX_W and LINE_ID_W its log2
`ifndef HYBCHE_CONSTS_SVH
`define HYBCHE_CONSTS_SVH

// Word address and data width
`define HYBCHE_ADDR_W 16
`define HYBCHE_WORD_W 32

// Word offset within a line, 4 words per line
`define HYBCHE_OFF_W 2

// Set index used in set-associative placement, 4 sets
`define HYBCHE_IDX_W 2

// Ways per set
`define HYBCHE_WAYS 4

// Total line slots, shared by both placement modes
`define HYBCHE_LINES 16

// Width of a line slot number
`define HYBCHE_LINE_ID_W 4

`endif

// File: design/hybche_ctrl_pkg.sv
// Control types; enum literals carry prefixes because both mode enums share names
`include "hybche_consts.svh"

package hybche_ctrl_pkg;

  import hybche_addr_pkg::*;

  // Placement override from the configuration register
  typedef enum logic [1:0] {
    FORCE_DYNAMIC    = 2'd0,
    FORCE_SET_ASSOC  = 2'd1,
    FORCE_FULL_ASSOC = 2'd2
  } force_mode_e;

  // What a placement mode change does to cached lines
  typedef enum logic {
    REPL_RETAIN = 1'b0,
    REPL_FLUSH  = 1'b1
  } repl_policy_e;

  // Placement mode in effect
  typedef enum logic {
    PLACE_SET_ASSOC  = 1'b0,
    PLACE_FULL_ASSOC = 1'b1
  } place_mode_e;

  // Configuration register, 3 bits
  typedef struct packed {
    force_mode_e  force_mode;
    repl_policy_e repl_policy;
  } cache_cfg_t;

  // Core request, 49 bits
  typedef struct packed {
    logic                      we;
    cache_addr_u               addr;
    logic [`HYBCHE_WORD_W-1:0] wdata;
  } core_req_t;

  // Memory command, 49 bits
  typedef struct packed {
    logic                      we;
    logic [`HYBCHE_ADDR_W-1:0] addr;
    logic [`HYBCHE_WORD_W-1:0] wdata;
  } mem_cmd_t;

endpackage

// File: design/hybche_line_store.sv
// Flops only, no SRAM macro; full line address is the tag so copies from either mode stay exact
`include "hybche_consts.svh"

module hybche_line_store import hybche_addr_pkg::*, hybche_ctrl_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  place_mode_e               place_mode_i,
  input  logic                      flush_all_i,
  // Lookup
  input  cache_addr_u               lookup_addr_i,
  output logic                      hit_o,
  output logic [`HYBCHE_WORD_W-1:0] hit_word_o,
  // Victim selection
  output line_id_t                  victim_o,
  input  logic                      alloc_i,
  // Refill
  input  logic                      refill_we_i,
  input  line_id_t                  refill_line_i,
  input  logic [`HYBCHE_OFF_W-1:0]  refill_off_i,
  input  logic [`HYBCHE_WORD_W-1:0] refill_word_i,
  input  logic                      refill_done_i,
  // Write-through
  input  logic                      wt_we_i,
  input  cache_addr_u               wt_addr_i,
  input  logic [`HYBCHE_WORD_W-1:0] wt_word_i
);

  localparam int WAY_W = `HYBCHE_LINE_ID_W - `HYBCHE_IDX_W;
  localparam int SETS  = 1 << `HYBCHE_IDX_W;

  line_addr_t                tag_q   [`HYBCHE_LINES];
  line_data_t                data_q  [`HYBCHE_LINES];
  logic [`HYBCHE_LINES-1:0]  valid_q;
  logic [WAY_W-1:0]          set_ptr_q [SETS];
  line_id_t                  glob_ptr_q;

  logic [`HYBCHE_WAYS-1:0]   sa_hit;
  logic [`HYBCHE_LINES-1:0]  fa_hit;
  logic [`HYBCHE_LINES-1:0]  wt_match;
  line_id_t                  hit_line;

  ////////////////////////////////////////////////////////////
  // Lookup
  ////////////////////////////////////////////////////////////

  // Tag compare in both views
  always_comb begin
    line_id_t sa_line;
    sa_line = '0;
    for (int w = 0; w < `HYBCHE_WAYS; w++) begin
      sa_line   = {lookup_addr_i.sa.index, WAY_W'(w)};
      // Index is part of the compare, a slot filled in FA mode may hold any set
      sa_hit[w] = valid_q[sa_line] &&
                  (tag_q[sa_line] == {lookup_addr_i.sa.tag, lookup_addr_i.sa.index});
    end
    for (int l = 0; l < `HYBCHE_LINES; l++) begin
      fa_hit[l] = valid_q[l] && (tag_q[l] == lookup_addr_i.fa.line_addr);
    end
  end

  // Hit line select, lowest match wins
  always_comb begin
    hit_o    = 1'b0;
    hit_line = '0;
    if (place_mode_i == PLACE_SET_ASSOC) begin
      for (int w = `HYBCHE_WAYS - 1; w >= 0; w--) begin
        if (sa_hit[w]) begin
          hit_o    = 1'b1;
          hit_line = {lookup_addr_i.sa.index, WAY_W'(w)};
        end
      end
    end else begin
      for (int l = `HYBCHE_LINES - 1; l >= 0; l--) begin
        if (fa_hit[l]) begin
          hit_o    = 1'b1;
          hit_line = line_id_t'(l);
        end
      end
    end
  end

  assign hit_word_o = data_q[hit_line][lookup_addr_i.fa.offset];

  // Round robin victim, per set or global
  assign victim_o = (place_mode_i == PLACE_SET_ASSOC) ?
                    {lookup_addr_i.sa.index, set_ptr_q[lookup_addr_i.sa.index]} :
                    glob_ptr_q;

  // Write-through hits every valid copy, whatever the mode
  always_comb begin
    for (int l = 0; l < `HYBCHE_LINES; l++) begin
      wt_match[l] = valid_q[l] && (tag_q[l] == wt_addr_i.fa.line_addr);
    end
  end

  ////////////////////////////////////////////////////////////
  // State update
  ////////////////////////////////////////////////////////////

  // Valid bits and pointers
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q    <= '0;
      glob_ptr_q <= '0;
      for (int s = 0; s < SETS; s++) begin
        set_ptr_q[s] <= '0;
      end
    end else begin
      // Slot is invalid while its refill runs
      if (alloc_i) begin
        valid_q[victim_o] <= 1'b0;
        if (place_mode_i == PLACE_SET_ASSOC) begin
          set_ptr_q[lookup_addr_i.sa.index] <= set_ptr_q[lookup_addr_i.sa.index] + 1'b1;
        end else begin
          glob_ptr_q <= glob_ptr_q + 1'b1;
        end
      end
      if (refill_done_i) begin
        valid_q[refill_line_i] <= 1'b1;
      end
      // Flush overrides everything above
      if (flush_all_i) begin
        valid_q    <= '0;
        glob_ptr_q <= '0;
        for (int s = 0; s < SETS; s++) begin
          set_ptr_q[s] <= '0;
        end
      end
    end
  end

  // Tags and data
  always_ff @(posedge clk_i) begin
    if (alloc_i) begin
      tag_q[victim_o] <= lookup_addr_i.fa.line_addr;
    end
    if (refill_we_i) begin
      data_q[refill_line_i][refill_off_i] <= refill_word_i;
    end
    if (wt_we_i) begin
      for (int l = 0; l < `HYBCHE_LINES; l++) begin
        if (wt_match[l]) begin
          data_q[l][wt_addr_i.fa.offset] <= wt_word_i;
        end
      end
    end
  end

  // Refills only follow an SA miss, so no set holds a line twice
  a_sa_onehot : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (place_mode_i == PLACE_SET_ASSOC) |-> $onehot0(sa_hit)
  );

endmodule

// File: design/hybche_miss_ctrl.sv
// One request at a time; the core must hold off while busy_o is high
`include "hybche_consts.svh"

module hybche_miss_ctrl import hybche_addr_pkg::*, hybche_ctrl_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Core side
  input  logic                      core_req_valid_i,
  input  core_req_t                 core_req_i,
  output logic                      busy_o,
  output logic                      core_rvalid_o,
  output logic [`HYBCHE_WORD_W-1:0] core_rdata_o,
  // Memory side
  output logic                      mem_req_o,
  output mem_cmd_t                  mem_cmd_o,
  input  logic                      mem_ack_i,
  input  logic [`HYBCHE_WORD_W-1:0] mem_rdata_i,
  // Line store
  output cache_addr_u               lookup_addr_o,
  input  logic                      hit_i,
  input  logic [`HYBCHE_WORD_W-1:0] hit_word_i,
  input  line_id_t                  victim_i,
  output logic                      alloc_o,
  output logic                      refill_we_o,
  output line_id_t                  refill_line_o,
  output logic [`HYBCHE_OFF_W-1:0]  refill_off_o,
  output logic [`HYBCHE_WORD_W-1:0] refill_word_o,
  output logic                      refill_done_o,
  output logic                      wt_we_o,
  output cache_addr_u               wt_addr_o,
  output logic [`HYBCHE_WORD_W-1:0] wt_word_o
);

  typedef enum logic [2:0] {IDLE, HIT_RESP, REFILL, WRITE, RESP} state_e;

  state_e                    state_q, state_d;
  logic [`HYBCHE_OFF_W-1:0]  beat_q;
  core_req_t                 req_q;
  line_id_t                  line_q;
  logic [`HYBCHE_WORD_W-1:0] rdata_q;

  // Busy only while memory traffic is pending
  assign busy_o        = (state_q == REFILL) || (state_q == WRITE);
  assign core_rvalid_o = (state_q == HIT_RESP) || (state_q == RESP);
  assign core_rdata_o  = rdata_q;

  // New request looks up directly, otherwise the held one
  assign lookup_addr_o = core_req_valid_i ? core_req_i.addr : req_q.addr;

  always_comb begin
    state_d       = state_q;
    alloc_o       = 1'b0;
    refill_we_o   = 1'b0;
    refill_done_o = 1'b0;
    case (state_q)
      // Response states accept the next request like IDLE
      IDLE, HIT_RESP, RESP: begin
        state_d = IDLE;
        if (core_req_valid_i) begin
          if (core_req_i.we) begin
            state_d = WRITE;
          end else if (hit_i) begin
            state_d = HIT_RESP;
          end else begin
            state_d = REFILL;
            alloc_o = 1'b1;
          end
        end
      end
      REFILL: begin
        if (mem_ack_i) begin
          refill_we_o = 1'b1;
          if (&beat_q) begin
            refill_done_o = 1'b1;
            state_d       = RESP;
          end
        end
      end
      WRITE: begin
        if (mem_ack_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  // Beat counter wraps to zero after the last word
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      beat_q  <= '0;
    end else begin
      state_q <= state_d;
      if (refill_we_o) begin
        beat_q <= beat_q + 1'b1;
      end
    end
  end

  // Request, victim and read data capture
  always_ff @(posedge clk_i) begin
    if (core_req_valid_i && !busy_o) begin
      req_q <= core_req_i;
    end
    if (alloc_o) begin
      line_q <= victim_i;
    end
    if (state_d == HIT_RESP) begin
      rdata_q <= hit_word_i;
    end
    // Requested word picked out of the refill stream
    if (refill_we_o && (beat_q == req_q.addr.fa.offset)) begin
      rdata_q <= mem_rdata_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Memory and store drive
  ////////////////////////////////////////////////////////////

  assign mem_req_o = busy_o;

  // Refill walks the line from offset 0
  always_comb begin
    mem_cmd_o.we    = (state_q == WRITE);
    mem_cmd_o.addr  = req_q.addr;
    mem_cmd_o.wdata = req_q.wdata;
    if (state_q == REFILL) begin
      mem_cmd_o.addr = {req_q.addr.fa.line_addr, beat_q};
    end
  end

  assign refill_line_o = line_q;
  assign refill_off_o  = beat_q;
  assign refill_word_o = mem_rdata_i;

  // Repeats each WRITE cycle with the same word
  assign wt_we_o   = (state_q == WRITE);
  assign wt_addr_o = req_q.addr;
  assign wt_word_o = req_q.wdata;

  a_no_req_busy : assert property (
    @(posedge clk_i) disable iff (!rst_ni) busy_o |-> !core_req_valid_i
  );

  a_cmd_stable : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (mem_req_o && !mem_ack_i) |=> (mem_req_o && $stable(mem_cmd_o))
  );

endmodule

// File: design/hybche_mode_cfg.sv
// Mode follows priv_lvl_i combinationally, so a privilege change acts in the same cycle
module hybche_mode_cfg import hybche_ctrl_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        cfg_we_i,
  input  cache_cfg_t  cfg_i,
  input  logic [1:0]  priv_lvl_i,
  input  logic        flush_i,
  output place_mode_e place_mode_o,
  output logic        flush_all_o,
  output logic        flush_ack_o
);

  // Machine privilege encoding
  localparam logic [1:0] PRIV_M = 2'b11;

  cache_cfg_t  cfg_q;
  place_mode_e mode_d;
  place_mode_e mode_q;
  logic        mode_change;
  logic        flush_ack_q;

  // Configuration register, new value seen from the next cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q <= '{force_mode: FORCE_DYNAMIC, repl_policy: REPL_RETAIN};
    end else if (cfg_we_i) begin
      cfg_q <= cfg_i;
    end
  end

  // Placement decision
  always_comb begin
    case (cfg_q.force_mode)
      FORCE_SET_ASSOC:  mode_d = PLACE_SET_ASSOC;
      FORCE_FULL_ASSOC: mode_d = PLACE_FULL_ASSOC;
      // Dynamic, and the unused encoding
      default: mode_d = (priv_lvl_i == PRIV_M) ? PLACE_FULL_ASSOC : PLACE_SET_ASSOC;
    endcase
  end

  // Previous mode and flush acknowledge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q      <= PLACE_SET_ASSOC;
      flush_ack_q <= 1'b0;
    end else begin
      mode_q      <= mode_d;
      flush_ack_q <= flush_i;
    end
  end

  assign mode_change  = (mode_d != mode_q);
  assign place_mode_o = mode_d;

  // Single-cycle flush: explicit request, or mode change under FLUSH policy
  // Valid bits drop at the end of this cycle
  assign flush_all_o = flush_i | (mode_change & (cfg_q.repl_policy == REPL_FLUSH));
  assign flush_ack_o = flush_ack_q;

  // Flush requests are single pulses, so acknowledges never merge
  a_flush_ack_pulse : assert property (
    @(posedge clk_i) disable iff (!rst_ni) flush_ack_o |=> !flush_ack_o
  );

endmodule

// File: design/hybche_top.sv
// Single core port, single memory port; flush_i only while busy_o is low
`include "hybche_consts.svh"

module hybche_top import hybche_addr_pkg::*, hybche_ctrl_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Core
  input  logic                      core_req_valid_i,
  input  core_req_t                 core_req_i,
  output logic                      busy_o,
  output logic                      core_rvalid_o,
  output logic [`HYBCHE_WORD_W-1:0] core_rdata_o,
  // Memory
  output logic                      mem_req_o,
  output mem_cmd_t                  mem_cmd_o,
  input  logic                      mem_ack_i,
  input  logic [`HYBCHE_WORD_W-1:0] mem_rdata_i,
  // Configuration and flush
  input  logic                      cfg_we_i,
  input  cache_cfg_t                cfg_i,
  input  logic [1:0]                priv_lvl_i,
  input  logic                      flush_i,
  output logic                      flush_ack_o
);

  place_mode_e               place_mode;
  logic                      flush_all;
  cache_addr_u               lookup_addr;
  logic                      hit;
  logic [`HYBCHE_WORD_W-1:0] hit_word;
  line_id_t                  victim;
  logic                      alloc;
  logic                      refill_we;
  line_id_t                  refill_line;
  logic [`HYBCHE_OFF_W-1:0]  refill_off;
  logic [`HYBCHE_WORD_W-1:0] refill_word;
  logic                      refill_done;
  logic                      wt_we;
  cache_addr_u               wt_addr;
  logic [`HYBCHE_WORD_W-1:0] wt_word;

  // Mode decision and flush generation
  hybche_mode_cfg u_mode_cfg (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cfg_we_i     (cfg_we_i),
    .cfg_i        (cfg_i),
    .priv_lvl_i   (priv_lvl_i),
    .flush_i      (flush_i),
    .place_mode_o (place_mode),
    .flush_all_o  (flush_all),
    .flush_ack_o  (flush_ack_o)
  );

  // Tags, valid bits and data
  hybche_line_store u_line_store (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .place_mode_i  (place_mode),
    .flush_all_i   (flush_all),
    .lookup_addr_i (lookup_addr),
    .hit_o         (hit),
    .hit_word_o    (hit_word),
    .victim_o      (victim),
    .alloc_i       (alloc),
    .refill_we_i   (refill_we),
    .refill_line_i (refill_line),
    .refill_off_i  (refill_off),
    .refill_word_i (refill_word),
    .refill_done_i (refill_done),
    .wt_we_i       (wt_we),
    .wt_addr_i     (wt_addr),
    .wt_word_i     (wt_word)
  );

  // Request sequencing and memory traffic
  hybche_miss_ctrl u_miss_ctrl (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .core_req_valid_i (core_req_valid_i),
    .core_req_i       (core_req_i),
    .busy_o           (busy_o),
    .core_rvalid_o    (core_rvalid_o),
    .core_rdata_o     (core_rdata_o),
    .mem_req_o        (mem_req_o),
    .mem_cmd_o        (mem_cmd_o),
    .mem_ack_i        (mem_ack_i),
    .mem_rdata_i      (mem_rdata_i),
    .lookup_addr_o    (lookup_addr),
    .hit_i            (hit),
    .hit_word_i       (hit_word),
    .victim_i         (victim),
    .alloc_o          (alloc),
    .refill_we_o      (refill_we),
    .refill_line_o    (refill_line),
    .refill_off_o     (refill_off),
    .refill_word_o    (refill_word),
    .refill_done_o    (refill_done),
    .wt_we_o          (wt_we),
    .wt_addr_o        (wt_addr),
    .wt_word_o        (wt_word)
  );

endmodule

// File: hybche.f
+incdir+design
design/hybche_addr_pkg.sv
design/hybche_ctrl_pkg.sv
design/hybche_mode_cfg.sv
design/hybche_line_store.sv
design/hybche_miss_ctrl.sv
design/hybche_top.sv
bench/hybche_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, and search the log for the failure line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f hybche.f --top-module hybche_tb \
  -o hybche_sim > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/hybche_sim > sim.log 2>&1 || { cat sim.log; echo "Simulation aborted"; exit 1; }

cat sim.log
grep -q "CHECKS FAILED" sim.log && exit 1 || exit 0
